// ==== flist.f ====
+incdir+source
source/ptwPkg.sv
source/walkArbiter.sv
source/pteDecoder.sv
source/pageWalker.sv
source/ptwTop.sv
tb/pteMemModel.sv
tb/ptwTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ptwTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TB PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/ptwTb.sv ====
`default_nettype none
`include "ptw_consts.svh"

module ptwTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_RQS = `PTW_NUM_RQS;
    localparam int NUM_TESTS = 6;
    localparam int NUM_VA = 11;
    localparam int WAIT_LIMIT = 300;
    localparam ptwPkg::rootPpnT ROOT_PPN = 20'h00001;
    localparam ptwPkg::ppnT L2_PPN = 22'h000002;

    logic clk;
    logic rst;
    ptwPkg::walkReqT rqs [NUM_RQS-1:0];
    ptwPkg::walkResT res;
    logic ldStall;
    ptwPkg::ldUOpT ldUOp;
    ptwPkg::ldAckT ldAck;
    ptwPkg::ldResT ldRes;

    ptwPkg::vaddrT vaList [0:NUM_VA-1];
    int errors = 0;
    int checks = 0;

    ptwTop #(
        .NUM_RQS(NUM_RQS)
    ) u_dut (
        .clk(clk),
        .rst(rst),
        .rqs(rqs),
        .res(res),
        .ldStall(ldStall),
        .ldUOp(ldUOp),
        .ldAck(ldAck),
        .ldRes(ldRes)
    );

    pteMemModel u_mem (
        .clk(clk),
        .rst(rst),
        .ldUOp(ldUOp),
        .ldStall(ldStall),
        .ldAck(ldAck),
        .ldRes(ldRes)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // step to 2 ns after the next rising edge
    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    // reset held over two rising edges
    task automatic resetDut();
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
    endtask

    function automatic ptwPkg::pteT makePte(ptwPkg::ppnT ppn, logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    function automatic ptwPkg::vaddrT vaOf(int vpn1, int vpn0);
        return {10'(vpn1), 10'(vpn0), 12'h3A4};
    endfunction

    task automatic setPte(ptwPkg::ppnT tablePpn, int idx, ptwPkg::pteT pte);
        u_mem.writeWord({tablePpn[19:0], 10'(idx), 2'b00}, pte);
    endtask

    // reference Sv32 walk over the table contents
    function automatic ptwPkg::walkResT expectRes(int id, ptwPkg::vaddrT va);
        ptwPkg::walkResT r;
        ptwPkg::pteT p;
        ptwPkg::ldAddrT nextAddr;
        logic superPage;
        logic fault;
        r = '0;
        r.valid = 1'b1;
        r.rqId = ptwPkg::rqIdT'(id);
        r.vpn = va[31:12];
        superPage = 1'b1;
        p = u_mem.readWord({ROOT_PPN, va[31:22], 2'b00});
        nextAddr = {p[29:10], va[21:12], 2'b00};
        if (p[3:0] == 4'b0001 && p[31:30] == 2'b00 && nextAddr < `PTW_MEM_LIMIT) begin
            p = u_mem.readWord(nextAddr);
            superPage = 1'b0;
        end
        fault = !p[0] || !p[6] || (p[3:1] inside {3'b000, 3'b010, 3'b110})
             || (superPage && p[19:10] != 10'd0);
        r.ppn = p[31:10];
        r.isSuperPage = superPage;
        r.pageFault = fault;
        if (!fault) begin
            r.rwx = {p[1], p[2] & p[7], p[3]};
            r.globl = p[5];
            r.user = p[4];
        end
        return r;
    endfunction

    task automatic checkRes(string name, ptwPkg::walkResT exp, ptwPkg::walkResT act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkId(string name, ptwPkg::rqIdT exp, ptwPkg::rqIdT act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // busy has to stay up from the cycle after the grant until the result
    task automatic waitRes(string name, output ptwPkg::walkResT got, output bit seen);
        seen = 1'b0;
        got = '0;
        for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
            nextCycle();
            if (res.valid) begin
                got = res;
                seen = 1'b1;
            end else if (!res.busy) begin
                errors++;
                $display("%s: walker was not busy while the walk was pending", name);
            end
        end
        if (!seen) begin
            errors++;
            $display("%s: no walk result within %0d cycles", name, WAIT_LIMIT);
        end
    endtask

    // requester holds its request until its result shows up
    task automatic runWalk(string name, int id, ptwPkg::vaddrT va);
        ptwPkg::walkResT got;
        bit seen;
        rqs[id] = '{valid: 1'b1, addr: va, rootPpn: ROOT_PPN};
        waitRes(name, got, seen);
        rqs[id].valid = 1'b0;
        if (seen) begin
            checkRes(name, expectRes(id, va), got);
        end
    endtask

    task automatic buildTables();
        ptwPkg::ppnT root;
        root = ptwPkg::ppnT'(ROOT_PPN);
        setPte(root, 1, makePte(L2_PPN, 8'h01));
        setPte(L2_PPN, 5, makePte(22'h012345, 8'hDF));
        // writable but clean, global
        setPte(L2_PPN, 6, makePte(22'h00ABCD, 8'h67));
        setPte(root, 3, makePte(22'h02AC00, 8'h4B));
        setPte(root, 4, makePte(22'h02AC01, 8'hCF));
        setPte(L2_PPN, 7, makePte(22'h000111, 8'hDE));
        setPte(L2_PPN, 8, makePte(22'h000222, 8'h9F));
        setPte(L2_PPN, 9, makePte(22'h000333, 8'h01));
        setPte(L2_PPN, 10, makePte(22'h000444, 8'hC5));
        setPte(L2_PPN, 11, makePte(22'h000555, 8'hCD));
        // next table lies past the legal memory range
        setPte(root, 5, makePte(22'h010000, 8'h01));
        vaList[0] = vaOf(1, 5);
        vaList[1] = vaOf(1, 6);
        vaList[2] = vaOf(3, 18);
        vaList[3] = vaOf(4, 0);
        vaList[4] = vaOf(1, 7);
        vaList[5] = vaOf(1, 8);
        vaList[6] = vaOf(1, 9);
        vaList[7] = vaOf(1, 10);
        vaList[8] = vaOf(1, 11);
        vaList[9] = vaOf(5, 2);
        vaList[10] = vaOf(2, 0);
    endtask

    task automatic idleTest();
        for (int n = 0; n < 10; n++) begin
            nextCycle();
            checks++;
            if (res.valid || res.busy || ldUOp.valid) begin
                errors++;
                $display("idle: DUT became active with no request pending");
            end
        end
    endtask

    task automatic twoLevelTest();
        runWalk("twoLevel dirty page", 0, vaList[0]);
        runWalk("twoLevel clean page", 1, vaList[1]);
    endtask

    task automatic superPageTest();
        runWalk("superPage aligned", 2, vaList[2]);
        runWalk("superPage misaligned", 0, vaList[3]);
    endtask

    task automatic faultTest();
        for (int i = 4; i < NUM_VA; i++) begin
            runWalk($sformatf("fault case %0d", i), i % NUM_RQS, vaList[i]);
        end
    endtask

    task automatic randomTest();
        u_mem.stallEn = 1'b1;
        u_mem.nackEn = 1'b1;
        for (int i = 0; i < NUM_VA; i++) begin
            runWalk($sformatf("random walk %0d", i), i % NUM_RQS, vaList[i]);
        end
        u_mem.stallEn = 1'b0;
        u_mem.nackEn = 1'b0;
        checks++;
        if (u_mem.stallCount == 0 || u_mem.nackCount == 0) begin
            errors++;
            $display("random: the load port never stalled or never sent a NACK");
        end
    endtask

    // all requesters held high, so grants rotate 0, 1, 2, 0
    // a fresh reset puts the round-robin pointer back on requester 0
    task automatic roundRobinTest();
        ptwPkg::walkResT got;
        bit seen;
        int id;
        resetDut();
        for (int i = 0; i < NUM_RQS; i++) begin
            rqs[i] = '{valid: 1'b1, addr: vaList[2 * i], rootPpn: ROOT_PPN};
        end
        for (int k = 0; k <= NUM_RQS; k++) begin
            waitRes("roundRobin", got, seen);
            if (!seen) begin
                break;
            end
            id = k % NUM_RQS;
            checkId("roundRobin order", ptwPkg::rqIdT'(id), got.rqId);
            checkRes("roundRobin result", expectRes(id, vaList[2 * id]), got);
        end
        for (int i = 0; i < NUM_RQS; i++) begin
            rqs[i].valid = 1'b0;
        end
    endtask

    initial begin
        #(NUM_TESTS * 2000);
        $display("timeout: the tests did not finish within %0d ns", NUM_TESTS * 2000);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        for (int i = 0; i < NUM_RQS; i++) begin
            rqs[i] = '0;
        end
        buildTables();
        resetDut();
        idleTest();
        twoLevelTest();
        superPageTest();
        faultTest();
        randomTest();
        roundRobinTest();
        errors += u_mem.holdErrors;
        $display("checks: %0d, errors: %0d, stall errors: %0d", checks, errors, u_mem.holdErrors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/pteMemModel.sv ====
`default_nettype none
`include "ptw_consts.svh"

module pteMemModel (
    input  wire             clk,
    input  wire             rst,
    input  ptwPkg::ldUOpT   ldUOp,
    output logic            ldStall,
    output ptwPkg::ldAckT   ldAck,
    output ptwPkg::ldResT   ldRes
);
    timeunit 1ns;
    timeprecision 100ps;

    // words by byte address, a missing word reads as zero
    ptwPkg::pteT mem [ptwPkg::ldAddrT];

    bit stallEn = 1'b0;
    bit nackEn = 1'b0;
    int seed = 89558;

    int stallCount = 0;
    int nackCount = 0;
    int holdErrors = 0;

    int delay = 0;
    ptwPkg::ldAddrT pendAddr;
    logic wasStalled = 1'b0;
    ptwPkg::ldAddrT stalledAddr;

    initial begin
        ldStall = 1'b0;
        ldAck = '0;
        ldRes = '0;
    end

    function automatic ptwPkg::pteT readWord(ptwPkg::ldAddrT a);
        return mem.exists(a) ? mem[a] : '0;
    endfunction

    task automatic writeWord(ptwPkg::ldAddrT a, ptwPkg::pteT data);
        mem[a] = data;
    endtask

    always @(posedge clk) begin
        logic issued;
        ptwPkg::ldAddrT addr;
        issued = !rst && ldUOp.valid && !ldStall;
        addr = ldUOp.addr;
        // a stalled load must still be there with the same address
        if (!rst && wasStalled && (!ldUOp.valid || ldUOp.addr !== stalledAddr)) begin
            holdErrors++;
            $display("load request changed while the port was stalled at %0t", $time);
        end
        wasStalled = !rst && ldUOp.valid && ldStall;
        stalledAddr = addr;
        if (wasStalled) begin
            stallCount++;
        end
        #2;
        ldAck = '0;
        ldRes = '0;
        ldStall = stallEn && ($unsigned($random(seed)) % 3 == 0);
        if (issued) begin
            if (nackEn && ($unsigned($random(seed)) % 4 == 0)) begin
                nackCount++;
                ldAck = '{valid: 1'b1, fail: 1'b1};
            end else begin
                pendAddr = addr;
                delay = 2 + $unsigned($random(seed)) % 3;
            end
        end else if (delay > 0) begin
            delay--;
            if (delay == 0) begin
                ldRes = '{valid: 1'b1, tag: `PTW_LD_TAG, data: readWord(pendAddr)};
            end
        end else if (nackEn && ($unsigned($random(seed)) % 5 == 0)) begin
            // result for some other load unit client
            ldRes = '{valid: 1'b1, tag: ptwPkg::ldTagT'(~`PTW_LD_TAG), data: $random(seed)};
        end
    end

endmodule

`default_nettype wire

// ==== source/ptwTop.sv ====
`default_nettype none
`include "ptw_consts.svh"

module ptwTop #(
    parameter int NUM_RQS = `PTW_NUM_RQS
) (
    input  wire              clk,
    input  wire              rst,

    input  ptwPkg::walkReqT  rqs [NUM_RQS-1:0],
    output ptwPkg::walkResT  res,

    input  wire              ldStall,
    output ptwPkg::ldUOpT    ldUOp,
    input  ptwPkg::ldAckT    ldAck,
    input  ptwPkg::ldResT    ldRes
);

    logic              idle;
    logic              grantValid;
    ptwPkg::rqIdT      grantId;
    ptwPkg::walkReqT   grantReq;

    ptwPkg::pteT       pte;
    logic              isLeafLevel;
    ptwPkg::vaddrT     walkAddr;
    ptwPkg::pteInfoT   pteInfo;

    walkArbiter #(
        .NUM_RQS(NUM_RQS)
    ) u_arbiter (
        .clk(clk),
        .rst(rst),
        .rqs(rqs),
        .idle(idle),
        .grantValid(grantValid),
        .grantId(grantId),
        .grantReq(grantReq)
    );

    pageWalker u_walker (
        .clk(clk),
        .rst(rst),
        .grantValid(grantValid),
        .grantId(grantId),
        .grantReq(grantReq),
        .idle(idle),
        .ldStall(ldStall),
        .ldUOp(ldUOp),
        .ldAck(ldAck),
        .ldRes(ldRes),
        .pteInfo(pteInfo),
        .pte(pte),
        .isLeafLevel(isLeafLevel),
        .walkAddr(walkAddr),
        .res(res)
    );

    pteDecoder u_decoder (
        .pte(pte),
        .isLeafLevel(isLeafLevel),
        .walkAddr(walkAddr),
        .info(pteInfo)
    );

endmodule

`default_nettype wire

// ==== source/pageWalker.sv ====
`default_nettype none
`include "ptw_consts.svh"

module pageWalker (
    input  wire              clk,
    input  wire              rst,

    // from the arbiter
    input  wire              grantValid,
    input  ptwPkg::rqIdT     grantId,
    input  ptwPkg::walkReqT  grantReq,
    output logic             idle,

    // shared load port
    input  wire              ldStall,
    output ptwPkg::ldUOpT    ldUOp,
    input  ptwPkg::ldAckT    ldAck,
    input  ptwPkg::ldResT    ldRes,

    // decoder side
    input  ptwPkg::pteInfoT  pteInfo,
    output ptwPkg::pteT      pte,
    output logic             isLeafLevel,
    output ptwPkg::vaddrT    walkAddr,

    // to the requesters
    output ptwPkg::walkResT  res
);

    ptwPkg::walkStateT state;

    // high while the walk is on the root table
    logic firstLevel;

    ptwPkg::vaddrT walkAddrQ;
    ptwPkg::rqIdT  rqIdQ;

    logic ldResValid;

    assign ldResValid = ldRes.valid && (ldRes.tag == `PTW_LD_TAG);

    assign idle = (state == ptwPkg::IDLE);

    // decoder sees the returned word directly
    assign pte = ldRes.data;
    assign isLeafLevel = !firstLevel;
    assign walkAddr = walkAddrQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ptwPkg::IDLE;
            ldUOp.valid <= 1'b0;
            res.valid <= 1'b0;
            res.busy <= 1'b0;
        end else begin
            // result is a single-cycle pulse
            res.valid <= 1'b0;

            case (state)
                ptwPkg::IDLE: begin
                    res.busy <= 1'b0;
                    if (grantValid) begin
                        state <= ptwPkg::WAIT_FOR_LOAD;
                        firstLevel <= 1'b1;
                        walkAddrQ <= grantReq.addr;
                        rqIdQ <= grantId;

                        // root table entry indexed by VPN1
                        ldUOp.valid <= 1'b1;
                        ldUOp.addr <= {grantReq.rootPpn, grantReq.addr[31:22], 2'b00};

                        res.busy <= 1'b1;
                        res.rqId <= grantId;
                    end
                end

                ptwPkg::WAIT_FOR_LOAD: begin
                    if (ldUOp.valid) begin
                        // held until the port takes it
                        if (!ldStall) begin
                            ldUOp.valid <= 1'b0;
                        end
                    end else if (ldResValid) begin
                        if (pteInfo.isPointer) begin
                            ldUOp.valid <= 1'b1;
                            ldUOp.addr <= pteInfo.nextAddr;
                            firstLevel <= 1'b0;
                        end else begin
                            state <= ptwPkg::IDLE;
                            res.valid <= 1'b1;
                            res.busy <= 1'b0;
                            res.rqId <= rqIdQ;
                            res.vpn <= walkAddrQ[31:12];
                            res.ppn <= pteInfo.ppn;
                            res.isSuperPage <= pteInfo.isSuperPage;
                            res.pageFault <= pteInfo.pageFault;
                            res.rwx <= pteInfo.rwx;
                            res.globl <= pteInfo.globl;
                            res.user <= pteInfo.user;
                        end
                    end else if (ldAck.valid && ldAck.fail) begin
                        // load unit had no room, try again with the same address
                        ldUOp.valid <= 1'b1;
                    end
                end

                default: begin
                    state <= ptwPkg::IDLE;
                end
            endcase
        end
    end

    resSinglePulse: assert property (
        @(posedge clk) disable iff (rst)
        res.valid |=> !res.valid
    );

    // a stalled load keeps its request and address
    ldAddrHeldOnStall: assert property (
        @(posedge clk) disable iff (rst)
        (ldUOp.valid && ldStall) |=> (ldUOp.valid && $stable(ldUOp.addr))
    );

endmodule

`default_nettype wire

// ==== source/pteDecoder.sv ====
`default_nettype none
`include "ptw_consts.svh"

module pteDecoder (
    input  ptwPkg::pteT     pte,
    input  wire             isLeafLevel,
    input  ptwPkg::vaddrT   walkAddr,
    output ptwPkg::pteInfoT info
);

    // Sv32 PTE bits: V=0 R=1 W=2 X=3 U=4 G=5 A=6 D=7
    ptwPkg::ldAddrT nextAddr;
    logic           isPointer;
    logic           leafFault;

    // second-level table entry indexed by VPN0
    assign nextAddr = {pte[29:10], walkAddr[21:12], 2'b00};

    assign isPointer = (pte[3:0] == 4'b0001)
                    && (pte[31:30] == 2'b00)
                    && !isLeafLevel
                    && `IS_LEGAL_ADDR(nextAddr);

    always_comb begin
        leafFault = 1'b0;
        // not valid or not accessed
        if (!pte[0] || !pte[6]) begin
            leafFault = 1'b1;
        end
        // invalid and reserved rwx encodings
        case (pte[3:1])
            3'b000,
            3'b010,
            3'b110: leafFault = 1'b1;
            default: ;
        endcase
        // misaligned superpage
        if (!isLeafLevel && (pte[19:10] != 10'd0)) begin
            leafFault = 1'b1;
        end
    end

    always_comb begin
        info.isPointer = isPointer;
        info.nextAddr = nextAddr;
        info.pageFault = !isPointer && leafFault;
        info.isSuperPage = !isLeafLevel;
        info.ppn = pte[31:10];
        info.rwx = '0;
        info.globl = 1'b0;
        info.user = 1'b0;
        if (!leafFault) begin
            // write only if already dirty, A/D updates are not done here
            info.rwx = {pte[1], pte[2] && pte[7], pte[3]};
            info.globl = pte[5];
            info.user = pte[4];
        end
    end

endmodule

`default_nettype wire

// ==== source/walkArbiter.sv ====
`default_nettype none
`include "ptw_consts.svh"

module walkArbiter #(
    parameter int NUM_RQS = `PTW_NUM_RQS
) (
    input  wire                   clk,
    input  wire                   rst,
    input  ptwPkg::walkReqT       rqs [NUM_RQS-1:0],
    input  wire                   idle,
    output logic                  grantValid,
    output ptwPkg::rqIdT          grantId,
    output ptwPkg::walkReqT       grantReq
);

    // index that gets first look in the next search
    ptwPkg::rqIdT rrPtr;

    // search from the pointer upward, wrapping around.
    // walking the offsets downward lets the lowest offset win
    always_comb begin
        int idx;
        grantValid = 1'b0;
        grantId = '0;
        for (int off = NUM_RQS - 1; off >= 0; off--) begin
            idx = (int'(rrPtr) + off) % NUM_RQS;
            if (idle && rqs[idx].valid) begin
                grantValid = 1'b1;
                grantId = ptwPkg::rqIdT'(idx);
            end
        end
    end

    assign grantReq = rqs[grantId];

    // pointer moves to one past the granted requester
    always_ff @(posedge clk) begin
        if (rst) begin
            rrPtr <= '0;
        end else if (grantValid) begin
            if (int'(grantId) == NUM_RQS - 1) begin
                rrPtr <= '0;
            end else begin
                rrPtr <= grantId + 2'd1;
            end
        end
    end

    // a grant lands on an idle walker, and the walker leaves idle right after
    grantWhileIdle: assert property (
        @(posedge clk) disable iff (rst)
        grantValid |-> idle ##1 !idle
    );

endmodule

`default_nettype wire

// ==== source/ptwPkg.sv ====
`default_nettype none

package ptwPkg;

    typedef logic [31:0] vaddrT;
    typedef logic [31:0] ldAddrT;
    typedef logic [31:0] pteT;
    typedef logic [21:0] ppnT;
    typedef logic [19:0] vpnT;
    // only the low 20 bits of satp.ppn reach the load address
    typedef logic [19:0] rootPpnT;
    typedef logic [1:0]  rqIdT;
    typedef logic [2:0]  rwxT;
    typedef logic [6:0]  ldTagT;

    typedef struct packed {
        logic    valid;
        vaddrT   addr;
        rootPpnT rootPpn;
    } walkReqT;

    typedef struct packed {
        logic valid;
        logic busy;
        rqIdT rqId;
        vpnT  vpn;
        ppnT  ppn;
        logic isSuperPage;
        logic pageFault;
        rwxT  rwx;
        logic globl;
        logic user;
    } walkResT;

    typedef struct packed {
        logic   valid;
        ldAddrT addr;
    } ldUOpT;

    typedef struct packed {
        logic valid;
        logic fail;
    } ldAckT;

    typedef struct packed {
        logic  valid;
        ldTagT tag;
        pteT   data;
    } ldResT;

    typedef struct packed {
        logic   isPointer;
        ldAddrT nextAddr;
        logic   pageFault;
        logic   isSuperPage;
        ppnT    ppn;
        rwxT    rwx;
        logic   globl;
        logic   user;
    } pteInfoT;

    typedef enum logic [0:0] {
        IDLE,
        WAIT_FOR_LOAD
    } walkStateT;

endpackage

`default_nettype wire

// ==== source/ptw_consts.svh ====
`ifndef PTW_CONSTS_SVH
`define PTW_CONSTS_SVH

// number of walk requesters (instruction and data TLB, plus one spare)
`define PTW_NUM_RQS 3

// tag on load results that belong to the walker
`define PTW_LD_TAG 7'h40

// first physical byte address outside the legal memory range
`define PTW_MEM_LIMIT 32'h1000_0000

// true when a physical byte address is inside the legal range
`define IS_LEGAL_ADDR(a) ((a) < `PTW_MEM_LIMIT)

`endif
